// ==== hw/reg_bus_pkg.sv ====
// Register-bus and APB transfer types shared by the host port, the demux and the
// targets. Users refer to items by scoped name.
package reg_bus_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Host request, held stable by the master until ready
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 write;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] wstrb;
    logic                 valid;
  } reg_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 ready;
    logic                 error;
  } reg_rsp_t;

  typedef struct packed {
    logic [AddrWidth-1:0] paddr;
    logic                 pwrite;
    logic [DataWidth-1:0] pwdata;
    logic [StrbWidth-1:0] pstrb;
    logic                 psel;
    logic                 penable;
  } apb_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] prdata;
    logic                 pready;
    logic                 pslverr;
  } apb_rsp_t;

  // Bridge phases
  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } apb_state_e;

endpackage

// ==== hw/soc_ctrl_pkg.sv ====
// Address map, control register layout, boot image and per-cluster constants
// of the SoC control fabric.
package soc_ctrl_pkg;

  localparam int unsigned NumClusters = 5;
  localparam int unsigned NumTargets  = 3;

  // ----------------------------------------------------------------------
  // Address map
  // ----------------------------------------------------------------------
  localparam logic [reg_bus_pkg::AddrWidth-1:0] RegsBase  = 32'h0000_0000;
  localparam logic [reg_bus_pkg::AddrWidth-1:0] RegsLimit = 32'h0000_00FF;
  localparam logic [reg_bus_pkg::AddrWidth-1:0] RomBase   = 32'h0000_0100;
  localparam logic [reg_bus_pkg::AddrWidth-1:0] RomLimit  = 32'h0000_01FF;
  localparam logic [reg_bus_pkg::AddrWidth-1:0] ApbBase   = 32'h0000_1000;
  localparam logic [reg_bus_pkg::AddrWidth-1:0] ApbLimit  = 32'h0000_1FFF;

  // Control register offsets
  localparam logic [7:0] ClkGateOffs = 8'h00;
  localparam logic [7:0] BypassOffs  = 8'h04;
  localparam logic [7:0] ScratchOffs = 8'h08;
  localparam logic [7:0] IdOffs      = 8'h0C;

  localparam logic [31:0] SocId = 32'hC41A_0001;

  // Boot stub: set trap vector, fetch entry word, jump or park in wfi
  localparam int unsigned BootRomWords = 16;
  localparam int unsigned RomIdxWidth  = $clog2(BootRomWords);
  localparam logic [31:0] BootRomImage [BootRomWords] = '{
    32'h0000_0297, 32'h0402_8293, 32'h3052_9073, 32'hF140_2573,
    32'h0000_0597, 32'h0385_8593, 32'h0005_A603, 32'h0006_0663,
    32'h0006_0067, 32'h0000_0013, 32'h1050_0073, 32'hFFDF_F06F,
    32'h0000_0013, 32'h0000_0013, 32'h0000_0000, 32'hC41A_0001
  };

  // Isolation settle time, counted down from IsoCntInit
  localparam int unsigned IsoSettleCycles = 4;
  localparam int unsigned IsoCntWidth     = $clog2(IsoSettleCycles);
  localparam logic [IsoCntWidth-1:0] IsoCntInit = IsoCntWidth'(IsoSettleCycles - 1);

  typedef enum logic [1:0] {
    TGT_REGS,
    TGT_ROM,
    TGT_APB,
    TGT_NONE
  } target_e;

  typedef struct packed {
    logic [NumClusters-1:0] clk_gate;
    logic [NumClusters-1:0] wide_bypass;
  } ctrl_cfg_t;

endpackage

// ==== hw/reg_demux.sv ====
// Host register-bus demux. Decodes the address onto one of three targets and
// answers unmapped accesses itself with an error one cycle after valid.
`timescale 1ns/10ps

module reg_demux (
  input  logic                                                      soc_clk_i,
  input  logic                                                      arst_n_i,
  input  reg_bus_pkg::reg_req_t                                     host_req_i,
  output reg_bus_pkg::reg_rsp_t                                     host_rsp_o,
  output reg_bus_pkg::reg_req_t [soc_ctrl_pkg::NumTargets-1:0]      tgt_req_o,
  input  reg_bus_pkg::reg_rsp_t [soc_ctrl_pkg::NumTargets-1:0]      tgt_rsp_i
);

  soc_ctrl_pkg::target_e tgt;
  logic                  err_ready_q;

  function automatic logic in_region(input logic [31:0] addr, input logic [31:0] base,
                                     input logic [31:0] limit);
    return (addr >= base) && (addr <= limit);
  endfunction

  always_comb begin
    if (in_region(host_req_i.addr, soc_ctrl_pkg::RegsBase, soc_ctrl_pkg::RegsLimit)) begin
      tgt = soc_ctrl_pkg::TGT_REGS;
    end else if (in_region(host_req_i.addr, soc_ctrl_pkg::RomBase, soc_ctrl_pkg::RomLimit)) begin
      tgt = soc_ctrl_pkg::TGT_ROM;
    end else if (in_region(host_req_i.addr, soc_ctrl_pkg::ApbBase, soc_ctrl_pkg::ApbLimit)) begin
      tgt = soc_ctrl_pkg::TGT_APB;
    end else begin
      tgt = soc_ctrl_pkg::TGT_NONE;
    end
  end

  // Same request to every target, valid only to the selected one
  always_comb begin
    for (int i = 0; i < soc_ctrl_pkg::NumTargets; i++) begin
      tgt_req_o[i]       = host_req_i;
      tgt_req_o[i].valid = host_req_i.valid && (tgt == soc_ctrl_pkg::target_e'(i));
    end
  end

  // Error responder for unmapped space
  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_ready_q <= 1'b0;
    end else begin
      err_ready_q <= host_req_i.valid && (tgt == soc_ctrl_pkg::TGT_NONE) && !err_ready_q;
    end
  end

  always_comb begin
    case (tgt)
      soc_ctrl_pkg::TGT_REGS: host_rsp_o = tgt_rsp_i[soc_ctrl_pkg::TGT_REGS];
      soc_ctrl_pkg::TGT_ROM:  host_rsp_o = tgt_rsp_i[soc_ctrl_pkg::TGT_ROM];
      soc_ctrl_pkg::TGT_APB:  host_rsp_o = tgt_rsp_i[soc_ctrl_pkg::TGT_APB];
      default: host_rsp_o = '{rdata: '0, ready: err_ready_q, error: err_ready_q};
    endcase
  end

  // Only the addressed target may answer
  a_one_target: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    $onehot0({tgt_rsp_i[soc_ctrl_pkg::TGT_REGS].ready, tgt_rsp_i[soc_ctrl_pkg::TGT_ROM].ready,
              tgt_rsp_i[soc_ctrl_pkg::TGT_APB].ready}));

endmodule

// ==== hw/ctrl_regs.sv ====
// Top-level control registers: cluster clock gates, wide-memory bypass, a
// scratch word and the read-only SoC ID. Response comes one cycle after valid.
`timescale 1ns/10ps

module ctrl_regs (
  input  logic                    soc_clk_i,
  input  logic                    arst_n_i,
  input  reg_bus_pkg::reg_req_t   req_i,
  output reg_bus_pkg::reg_rsp_t   rsp_o,
  output soc_ctrl_pkg::ctrl_cfg_t cfg_o
);

  soc_ctrl_pkg::ctrl_cfg_t cfg_q;
  logic [31:0]             scratch_q;
  logic                    ready_q, err_q;
  logic [31:0]             rdata_q;
  logic [7:0]              offs;
  logic                    access;
  logic [31:0]             gate_new, bypass_new, scratch_new;
  logic [31:0]             rdata_d;
  logic                    err_d;

  // Byte-strobed merge of write data into a register value
  function automatic logic [31:0] apply_strb(input logic [31:0] old_val,
                                             input logic [31:0] wdata, input logic [3:0] wstrb);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) res[8*b+:8] = wdata[8*b+:8];
    end
    return res;
  endfunction

  assign offs   = 8'(req_i.addr - soc_ctrl_pkg::RegsBase);
  assign access = req_i.valid && !ready_q;

  assign gate_new    = apply_strb(32'(cfg_q.clk_gate), req_i.wdata, req_i.wstrb);
  assign bypass_new  = apply_strb(32'(cfg_q.wide_bypass), req_i.wdata, req_i.wstrb);
  assign scratch_new = apply_strb(scratch_q, req_i.wdata, req_i.wstrb);

  // Read mux and offset check
  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    case (offs)
      soc_ctrl_pkg::ClkGateOffs: rdata_d = 32'(cfg_q.clk_gate);
      soc_ctrl_pkg::BypassOffs:  rdata_d = 32'(cfg_q.wide_bypass);
      soc_ctrl_pkg::ScratchOffs: rdata_d = scratch_q;
      soc_ctrl_pkg::IdOffs:      rdata_d = soc_ctrl_pkg::SocId;
      default:                   err_d   = 1'b1;
    endcase
  end

  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q     <= '0;
      scratch_q <= '0;
      ready_q   <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      ready_q <= access;
      err_q   <= access && err_d;
      if (access && req_i.write) begin
        // ID offset falls through, writes there are dropped
        case (offs)
          soc_ctrl_pkg::ClkGateOffs: cfg_q.clk_gate <= gate_new[soc_ctrl_pkg::NumClusters-1:0];
          soc_ctrl_pkg::BypassOffs:  cfg_q.wide_bypass <= bypass_new[soc_ctrl_pkg::NumClusters-1:0];
          soc_ctrl_pkg::ScratchOffs: scratch_q <= scratch_new;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (access) rdata_q <= req_i.write ? '0 : rdata_d;
  end

  assign rsp_o = '{rdata: rdata_q, ready: ready_q, error: err_q};
  assign cfg_o = cfg_q;

  a_ready_pulse: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    rsp_o.ready |=> !rsp_o.ready);

endmodule

// ==== hw/reg_to_apb.sv ====
// Register-bus to APB bridge for the external configuration window. Each host
// access becomes one APB setup/access transfer; paddr is the window offset.
`timescale 1ns/10ps

module reg_to_apb (
  input  logic                  soc_clk_i,
  input  logic                  arst_n_i,
  input  reg_bus_pkg::reg_req_t req_i,
  output reg_bus_pkg::reg_rsp_t rsp_o,
  output reg_bus_pkg::apb_req_t apb_req_o,
  input  reg_bus_pkg::apb_rsp_t apb_rsp_i
);

  reg_bus_pkg::apb_state_e state_q, state_d;

  logic [reg_bus_pkg::AddrWidth-1:0] paddr_q;
  logic [reg_bus_pkg::DataWidth-1:0] pwdata_q;
  logic [reg_bus_pkg::StrbWidth-1:0] pstrb_q;
  logic                              pwrite_q;
  logic                              done;

  assign done = (state_q == reg_bus_pkg::ACCESS) && apb_rsp_i.pready;

  // ----------------------------------------------------------------------
  // Phase FSM
  // ----------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      reg_bus_pkg::IDLE:   if (req_i.valid) state_d = reg_bus_pkg::SETUP;
      reg_bus_pkg::SETUP:  state_d = reg_bus_pkg::ACCESS;
      reg_bus_pkg::ACCESS: if (apb_rsp_i.pready) state_d = reg_bus_pkg::IDLE;
      default:             state_d = reg_bus_pkg::IDLE;
    endcase
  end

  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= reg_bus_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Transfer payload, captured as the transfer starts
  always_ff @(posedge soc_clk_i) begin
    if (state_q == reg_bus_pkg::IDLE && req_i.valid) begin
      paddr_q  <= req_i.addr - soc_ctrl_pkg::ApbBase;
      pwdata_q <= req_i.wdata;
      pstrb_q  <= req_i.write ? req_i.wstrb : '0;
      pwrite_q <= req_i.write;
    end
  end

  assign apb_req_o = '{
    paddr:   paddr_q,
    pwrite:  pwrite_q,
    pwdata:  pwdata_q,
    pstrb:   pstrb_q,
    psel:    state_q != reg_bus_pkg::IDLE,
    penable: state_q == reg_bus_pkg::ACCESS
  };

  assign rsp_o = '{rdata: apb_rsp_i.prdata, ready: done, error: done && apb_rsp_i.pslverr};

  a_enable_sel: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    apb_req_o.penable |-> apb_req_o.psel);

  // Address must not move once the setup phase has presented it
  a_addr_stable: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    apb_req_o.penable |-> $stable(apb_req_o.paddr));

endmodule

// ==== hw/bootrom_port.sv ====
// Boot ROM behind a register port. Data, ready and error are registered
// together and appear one cycle after valid; writes are refused.
`timescale 1ns/10ps

module bootrom_port (
  input  logic                  soc_clk_i,
  input  logic                  arst_n_i,
  input  reg_bus_pkg::reg_req_t req_i,
  output reg_bus_pkg::reg_rsp_t rsp_o
);

  logic [reg_bus_pkg::AddrWidth-1:0] offs;
  logic [reg_bus_pkg::AddrWidth-1:0] word_idx;
  logic [31:0]                       rom_word;
  logic                              access;
  logic                              ready_q, err_q;
  logic [31:0]                       rdata_q;

  assign offs     = req_i.addr - soc_ctrl_pkg::RomBase;
  assign word_idx = offs >> 2;
  assign access   = req_i.valid && !ready_q;

  // Words past the image read as zero
  always_comb begin
    if (word_idx < soc_ctrl_pkg::BootRomWords) begin
      rom_word = soc_ctrl_pkg::BootRomImage[word_idx[soc_ctrl_pkg::RomIdxWidth-1:0]];
    end else begin
      rom_word = '0;
    end
  end

  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ready_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      ready_q <= access;
      err_q   <= access && req_i.write;
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (access) rdata_q <= req_i.write ? '0 : rom_word;
  end

  assign rsp_o = '{rdata: rdata_q, ready: ready_q, error: err_q};

endmodule

// ==== hw/cluster_ctrl.sv ====
// Per-cluster clock gate and PMU isolation handshake. The PMU raises iso_req_i
// and waits for iso_ack_o; dropping the request releases isolation.
`timescale 1ns/10ps

module cluster_ctrl (
  input  logic soc_clk_i,
  input  logic arst_n_i,
  input  logic gate_en_i,
  input  logic iso_req_i,
  output logic iso_o,
  output logic iso_ack_o,
  output logic clu_clk_o
);

  typedef enum logic [1:0] {
    ISO_IDLE,
    ISO_SETTLE,
    ISO_ACK
  } iso_state_e;

  iso_state_e                             state_q;
  logic [soc_ctrl_pkg::IsoCntWidth-1:0]   cnt_q;
  logic                                   clk_en_l;

  // ----------------------------------------------------------------------
  // Clock gate
  // ----------------------------------------------------------------------
  // Enable only changes while the clock is low
  always_latch begin
    if (!soc_clk_i) begin
      clk_en_l <= !gate_en_i;
    end
  end

  assign clu_clk_o = soc_clk_i & clk_en_l;

  // ----------------------------------------------------------------------
  // Isolation handshake
  // ----------------------------------------------------------------------
  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ISO_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ISO_IDLE: begin
          if (iso_req_i) begin
            state_q <= ISO_SETTLE;
            cnt_q   <= soc_ctrl_pkg::IsoCntInit;
          end
        end
        ISO_SETTLE: begin
          if (cnt_q == '0) state_q <= ISO_ACK;
          else             cnt_q   <= cnt_q - 1'b1;
        end
        ISO_ACK: begin
          if (!iso_req_i) state_q <= ISO_IDLE;
        end
        default: state_q <= ISO_IDLE;
      endcase
    end
  end

  assign iso_o     = state_q != ISO_IDLE;
  assign iso_ack_o = state_q == ISO_ACK;

  // Ack only once isolation has been held for the full settle time
  a_ack_settled: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    iso_ack_o |-> iso_o && $past(iso_o, soc_ctrl_pkg::IsoSettleCycles));

endmodule

// ==== hw/soc_ctrl_top.sv ====
// SoC control fabric top. Host register bus fans out to control registers,
// boot ROM and the APB window; each cluster gets a clock gate and iso handshake.
`timescale 1ns/10ps

module soc_ctrl_top (
  input  logic                                 soc_clk_i,
  input  logic                                 arst_n_i,
  input  reg_bus_pkg::reg_req_t                reg_req_i,
  output reg_bus_pkg::reg_rsp_t                reg_rsp_o,
  output reg_bus_pkg::apb_req_t                apb_req_o,
  input  reg_bus_pkg::apb_rsp_t                apb_rsp_i,
  input  logic [soc_ctrl_pkg::NumClusters-1:0] iso_req_i,
  output logic [soc_ctrl_pkg::NumClusters-1:0] iso_o,
  output logic [soc_ctrl_pkg::NumClusters-1:0] iso_ack_o,
  output logic [soc_ctrl_pkg::NumClusters-1:0] clu_clk_o,
  output logic [soc_ctrl_pkg::NumClusters-1:0] wide_bypass_o
);

  reg_bus_pkg::reg_req_t [soc_ctrl_pkg::NumTargets-1:0] tgt_req;
  reg_bus_pkg::reg_rsp_t [soc_ctrl_pkg::NumTargets-1:0] tgt_rsp;
  soc_ctrl_pkg::ctrl_cfg_t                              cfg;

  // ----------------------------------------------------------------------
  // Register bus
  // ----------------------------------------------------------------------
  reg_demux i_reg_demux (
    .soc_clk_i (soc_clk_i),
    .arst_n_i  (arst_n_i),
    .host_req_i(reg_req_i),
    .host_rsp_o(reg_rsp_o),
    .tgt_req_o (tgt_req),
    .tgt_rsp_i (tgt_rsp)
  );

  ctrl_regs i_ctrl_regs (
    .soc_clk_i(soc_clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (tgt_req[soc_ctrl_pkg::TGT_REGS]),
    .rsp_o    (tgt_rsp[soc_ctrl_pkg::TGT_REGS]),
    .cfg_o    (cfg)
  );

  bootrom_port i_bootrom_port (
    .soc_clk_i(soc_clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (tgt_req[soc_ctrl_pkg::TGT_ROM]),
    .rsp_o    (tgt_rsp[soc_ctrl_pkg::TGT_ROM])
  );

  // External config window
  reg_to_apb i_reg_to_apb (
    .soc_clk_i(soc_clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (tgt_req[soc_ctrl_pkg::TGT_APB]),
    .rsp_o    (tgt_rsp[soc_ctrl_pkg::TGT_APB]),
    .apb_req_o(apb_req_o),
    .apb_rsp_i(apb_rsp_i)
  );

  assign wide_bypass_o = cfg.wide_bypass;

  // ----------------------------------------------------------------------
  // Per-cluster control
  // ----------------------------------------------------------------------
  for (genvar k = 0; k < soc_ctrl_pkg::NumClusters; k++) begin : gen_cluster
    cluster_ctrl i_cluster_ctrl (
      .soc_clk_i(soc_clk_i),
      .arst_n_i (arst_n_i),
      .gate_en_i(cfg.clk_gate[k]),
      .iso_req_i(iso_req_i[k]),
      .iso_o    (iso_o[k]),
      .iso_ack_o(iso_ack_o[k]),
      .clu_clk_o(clu_clk_o[k])
    );
  end

endmodule

// ==== dv/tb_soc_ctrl.sv ====
// Testbench for the SoC control fabric. Drives the host register bus and the PMU
// isolation requests, models an APB slave, and checks every response against a model.
`timescale 1ns/10ps

module tb_soc_ctrl;

  localparam int          Timeout  = 100;
  localparam int          ApbWords = 512;
  localparam int unsigned NumClu   = soc_ctrl_pkg::NumClusters;

  logic                  clk = 1'b0;
  logic                  arst_n;
  reg_bus_pkg::reg_req_t reg_req;
  reg_bus_pkg::reg_rsp_t reg_rsp;
  reg_bus_pkg::apb_req_t apb_req;
  reg_bus_pkg::apb_rsp_t apb_rsp;
  logic [NumClu-1:0]     iso_req;
  logic [NumClu-1:0]     iso;
  logic [NumClu-1:0]     iso_ack;
  logic [NumClu-1:0]     clu_clk;
  logic [NumClu-1:0]     wide_bypass;

  // Register model and APB memories
  logic [NumClu-1:0] gate_m;
  logic [NumClu-1:0] bypass_m;
  logic [31:0]       scratch_m;
  logic [31:0]       apb_model [ApbWords];
  logic [31:0]       slave_mem [ApbWords];
  int                fail_count = 0;

  // Rising edges seen on each cluster clock
  int unsigned       edge_cnt [NumClu] = '{default: 0};
  logic [NumClu-1:0] clu_clk_prev = '0;

  always #4 clk = ~clk;

  soc_ctrl_top dut (
    .soc_clk_i    (clk),
    .arst_n_i     (arst_n),
    .reg_req_i    (reg_req),
    .reg_rsp_o    (reg_rsp),
    .apb_req_o    (apb_req),
    .apb_rsp_i    (apb_rsp),
    .iso_req_i    (iso_req),
    .iso_o        (iso),
    .iso_ack_o    (iso_ack),
    .clu_clk_o    (clu_clk),
    .wide_bypass_o(wide_bypass)
  );

  always @(clu_clk) begin
    for (int c = 0; c < NumClu; c++) begin
      if (clu_clk[c] && !clu_clk_prev[c]) edge_cnt[c] = edge_cnt[c] + 1;
    end
    clu_clk_prev = clu_clk;
  end

  // ----------------------------------------------------------------------
  // Model helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  wstrb);
    logic [31:0] mask;
    mask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
    return (old_val & ~mask) | (wdata & mask);
  endfunction

  // Initial memory contents, spread over the whole word index
  function automatic logic [31:0] fill_word(input int unsigned idx);
    return (idx * 32'h9E37_79B1) ^ 32'h5A5A_0000;
  endfunction

  function automatic logic [31:0] model_read(input logic [7:0] offs);
    case (offs)
      soc_ctrl_pkg::ClkGateOffs: return 32'(gate_m);
      soc_ctrl_pkg::BypassOffs:  return 32'(bypass_m);
      soc_ctrl_pkg::ScratchOffs: return scratch_m;
      default:                   return soc_ctrl_pkg::SocId;
    endcase
  endfunction

  task automatic stop_on_failure();
    fail_count++;
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic timed_out(input string what);
    $display("Timeout while waiting for %s", what);
    stop_on_failure();
  endtask

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERR %s: expected 0x%08h, actual 0x%08h", test, expected, actual);
      stop_on_failure();
    end
  endtask

  // One host access; latency counts clock edges from valid to ready
  task automatic bus_access(input logic [31:0] addr, input logic write,
                            input logic [31:0] wdata, input logic [3:0] wstrb,
                            output logic [31:0] rdata, output logic error,
                            output int latency);
    reg_bus_pkg::reg_req_t req;
    logic                  done;
    req.addr  = addr;
    req.write = write;
    req.wdata = wdata;
    req.wstrb = wstrb;
    req.valid = 1'b1;
    latency   = 0;
    done      = 1'b0;
    @(posedge clk);
    reg_req <= req;
    while (!done) begin
      @(negedge clk);
      if (reg_rsp.ready) begin
        done  = 1'b1;
        rdata = reg_rsp.rdata;
        error = reg_rsp.error;
      end else begin
        latency++;
        if (latency > Timeout) timed_out("register bus ready");
      end
    end
    @(posedge clk);
    reg_req.valid <= 1'b0;
  endtask

  // Full four-phase isolation cycle on one cluster
  task automatic check_isolation(input int k);
    int   cycles;
    int   iso_lat;
    logic acked;
    logic released;
    cycles  = 0;
    iso_lat = -1;
    acked   = 1'b0;
    @(posedge clk);
    iso_req[k] <= 1'b1;
    while (!acked) begin
      @(negedge clk);
      if (iso[k] && iso_lat < 0) iso_lat = cycles;
      if (iso_ack[k]) begin
        acked = 1'b1;
      end else begin
        cycles++;
        if (cycles > Timeout) timed_out("isolation ack");
      end
    end
    check_value("iso_rise", 1, iso_lat);
    check_value("iso_ack_rise", 1 + soc_ctrl_pkg::IsoSettleCycles, cycles);
    cycles   = 0;
    released = 1'b0;
    @(posedge clk);
    iso_req[k] <= 1'b0;
    while (!released) begin
      @(negedge clk);
      if (!iso[k]) begin
        released = 1'b1;
      end else begin
        cycles++;
        if (cycles > Timeout) timed_out("isolation release");
      end
    end
    check_value("iso_fall", 1, cycles);
    check_value("iso_ack_fall", 0, 32'(iso_ack[k]));
  endtask

  // ----------------------------------------------------------------------
  // APB slave with random wait states
  // ----------------------------------------------------------------------
  initial begin
    reg_bus_pkg::apb_rsp_t rsp;
    logic [31:0]           r;
    logic [1:0]            waits;
    logic [8:0]            w;
    apb_rsp = '0;
    waits   = '0;
    for (int i = 0; i < ApbWords; i++) begin
      slave_mem[i] = fill_word(i);
    end
    forever begin
      @(posedge clk);
      rsp = '0;
      if (apb_req.psel && !apb_req.penable) begin
        r     = $urandom;
        waits = r[1:0];
      end else if (apb_req.psel && apb_req.penable && !apb_rsp.pready) begin
        if (waits != 2'd0) begin
          waits = waits - 2'd1;
        end else begin
          w           = apb_req.paddr[10:2];
          rsp.pready  = 1'b1;
          rsp.pslverr = apb_req.paddr >= 32'h0000_0800;
          if (!rsp.pslverr && apb_req.pwrite) begin
            slave_mem[w] = merge_bytes(slave_mem[w], apb_req.pwdata, apb_req.pstrb);
          end else if (!rsp.pslverr) begin
            rsp.prdata = slave_mem[w];
          end
        end
      end
      apb_rsp <= rsp;
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus and checks
  // ----------------------------------------------------------------------
  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] tmp;
    logic [3:0]  wstrb;
    logic [7:0]  offs;
    logic [5:0]  ridx;
    logic [8:0]  w;
    logic        err;
    int          lat;
    int unsigned start_cnt [NumClu];

    void'($urandom(68431));
    arst_n    = 1'b0;
    reg_req   = '0;
    iso_req   = '0;
    gate_m    = '0;
    bypass_m  = '0;
    scratch_m = '0;
    for (int i = 0; i < ApbWords; i++) begin
      apb_model[i] = fill_word(i);
    end
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);

    // Reset values
    for (int i = 0; i < 4; i++) begin
      offs = 8'(i * 4);
      bus_access(soc_ctrl_pkg::RegsBase + 32'(offs), 1'b0, '0, '0, rdata, err, lat);
      check_value("reset_value", model_read(offs), rdata);
      check_value("reset_error", 0, 32'(err));
      check_value("reset_latency", 1, lat);
    end

    // Random byte-strobed writes, ID included
    for (int i = 0; i < 40; i++) begin
      r     = $urandom;
      wdata = $urandom;
      wstrb = r[7:4];
      offs  = {4'h0, r[1:0], 2'b00};
      bus_access(soc_ctrl_pkg::RegsBase + 32'(offs), 1'b1, wdata, wstrb, rdata, err, lat);
      check_value("reg_write_error", 0, 32'(err));
      check_value("reg_write_latency", 1, lat);
      case (offs)
        soc_ctrl_pkg::ClkGateOffs: begin
          tmp    = merge_bytes(32'(gate_m), wdata, wstrb);
          gate_m = tmp[NumClu-1:0];
        end
        soc_ctrl_pkg::BypassOffs: begin
          tmp      = merge_bytes(32'(bypass_m), wdata, wstrb);
          bypass_m = tmp[NumClu-1:0];
        end
        soc_ctrl_pkg::ScratchOffs: scratch_m = merge_bytes(scratch_m, wdata, wstrb);
        default: ;
      endcase
      bus_access(soc_ctrl_pkg::RegsBase + 32'(offs), 1'b0, '0, '0, rdata, err, lat);
      check_value("reg_readback", model_read(offs), rdata);
    end

    // Unused register offsets
    for (int i = 0; i < 8; i++) begin
      r    = $urandom;
      offs = 8'h10 + 8'(r[6:0]);
      bus_access(soc_ctrl_pkg::RegsBase + 32'(offs), r[8], $urandom, 4'hF, rdata, err, lat);
      check_value("unused_offs_error", 1, 32'(err));
      check_value("unused_offs_latency", 1, lat);
    end

    // Boot ROM
    for (int i = 0; i < 30; i++) begin
      r    = $urandom;
      ridx = r[5:0];
      addr = soc_ctrl_pkg::RomBase + {24'b0, ridx, 2'b00};
      bus_access(addr, r[8], $urandom, 4'hF, rdata, err, lat);
      check_value("rom_latency", 1, lat);
      if (r[8]) begin
        check_value("rom_write_error", 1, 32'(err));
      end else begin
        check_value("rom_read_error", 0, 32'(err));
        if (ridx < 6'd16) begin
          check_value("rom_read", soc_ctrl_pkg::BootRomImage[ridx[3:0]], rdata);
        end else begin
          check_value("rom_read_past_image", 0, rdata);
        end
      end
    end

    // APB window, a small word set so reads hit earlier writes
    for (int i = 0; i < 60; i++) begin
      r     = $urandom;
      wdata = $urandom;
      wstrb = r[16:13];
      w     = {5'b0, r[5:2]};
      addr  = soc_ctrl_pkg::ApbBase + {20'b0, r[11], 5'b0, r[5:2], 2'b00};
      bus_access(addr, r[12], wdata, wstrb, rdata, err, lat);
      check_value("apb_error", 32'(r[11]), 32'(err));
      assert (lat >= 2) else begin
        $display("APB access answered after %0d cycles, below the two-cycle minimum", lat);
        stop_on_failure();
      end
      if (!r[11] && r[12]) begin
        apb_model[w] = merge_bytes(apb_model[w], wdata, wstrb);
      end else if (!r[11]) begin
        check_value("apb_read", apb_model[w], rdata);
      end
    end

    // Unmapped space
    for (int i = 0; i < 10; i++) begin
      r  = $urandom;
      r2 = $urandom;
      case (r[1:0])
        2'd0:    addr = 32'h0000_0200 + {22'b0, r2[9:2], 2'b00};
        2'd1:    addr = 32'h0000_2000 + {16'b0, r2[15:2], 2'b00};
        2'd2:    addr = 32'hF000_0000 | {4'b0, r2[27:0]};
        default: addr = 32'h0000_0800 + {22'b0, r2[9:2], 2'b00};
      endcase
      bus_access(addr, r[4], $urandom, 4'hF, rdata, err, lat);
      check_value("unmapped_error", 1, 32'(err));
      check_value("unmapped_rdata", 0, rdata);
      check_value("unmapped_latency", 1, lat);
    end

    // Clock gating
    for (int i = 0; i < 4; i++) begin
      wdata = $urandom;
      addr  = soc_ctrl_pkg::RegsBase + 32'(soc_ctrl_pkg::ClkGateOffs);
      bus_access(addr, 1'b1, wdata, 4'hF, rdata, err, lat);
      gate_m = wdata[NumClu-1:0];
      repeat (2) @(posedge clk);
      @(negedge clk);
      for (int c = 0; c < NumClu; c++) begin
        start_cnt[c] = edge_cnt[c];
      end
      repeat (20) @(negedge clk);
      for (int c = 0; c < NumClu; c++) begin
        check_value("clk_gate_edges", gate_m[c] ? 32'd0 : 32'd20, edge_cnt[c] - start_cnt[c]);
      end
    end

    // Wide-memory bypass
    for (int i = 0; i < 4; i++) begin
      wdata = $urandom;
      addr  = soc_ctrl_pkg::RegsBase + 32'(soc_ctrl_pkg::BypassOffs);
      bus_access(addr, 1'b1, wdata, 4'hF, rdata, err, lat);
      bypass_m = wdata[NumClu-1:0];
      check_value("wide_bypass", 32'(bypass_m), 32'(wide_bypass));
    end

    // Isolation on random clusters
    for (int i = 0; i < 8; i++) begin
      r = $urandom;
      check_isolation(int'(r % NumClu));
    end

    repeat (2) @(posedge clk);
    if (fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/reg_bus_pkg.sv
hw/soc_ctrl_pkg.sv
hw/reg_demux.sv
hw/ctrl_regs.sv
hw/reg_to_apb.sv
hw/bootrom_port.sv
hw/cluster_ctrl.sv
hw/soc_ctrl_top.sv
dv/tb_soc_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for failures
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_soc_ctrl \
  -f filelist.f --Mdir obj_dir -o sim_soc_ctrl
./obj_dir/sim_soc_ctrl 2>&1 | tee sim.log
if grep -q "Done: errors found" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
